/* hw/obj_table_pkg.sv */
// Sprite table layout and scan definitions
package obj_table_pkg;

    // Entries walked by the scanner on every line
    localparam int unsigned obj_entries = 24;

    // Entries below this index read their Y one line late
    localparam int unsigned obj_half = 19;

    // Scanner word address, two bytes per entry in each table
    localparam int unsigned obj_tab_aw = 6;

    // Sprite height in lines
    localparam int unsigned obj_band = 16;

    // Scanner steps for one entry
    // read_pos reads attribute and X, read_code reads Y and code
    typedef enum logic [1:0] {
        idle,
        read_pos,
        read_code,
        settle
    } scan_state_t;

endpackage

/* hw/obj_draw_pkg.sv */
// Sprite drawer definitions
package obj_draw_pkg;

    // Graphics ROM address is code, row and half select
    localparam int unsigned gfx_aw = 13;

    // One ROM word holds eight 4-bit pixels
    localparam int unsigned gfx_dw = 32;

    // Pixel and palette output width
    localparam int unsigned pix_w = 4;

    // Line buffer X offset, covers the blanking delay
    localparam logic [7:0] obj_hoffset = 8'd6;

    typedef enum logic [1:0] {
        idle,
        fetch,
        shift
    } draw_state_t;

endpackage

/* hw/sprite_ram.sv */
// Sprite attribute tables
module sprite_ram (
    input  logic                                 clk,
    input  logic [9:0]                           cpu_addr,
    input  logic [7:0]                           cpu_dout,
    input  logic                                 lo_cs,
    input  logic                                 hi_cs,
    input  logic                                 cpu_rnw,
    output logic [7:0]                           obj_dout,
    input  logic [obj_table_pkg::obj_tab_aw-1:0] scan_addr,
    output logic [7:0]                           lo_q,
    output logic [7:0]                           hi_q
);
    import obj_table_pkg::*;

    // Table 0 is the low table (attribute, Y), table 1 the high table (X, code)
    logic [7:0] mem [2][1024];
    logic [7:0] cpu_rd [2];
    logic [7:0] scan_rd [2];
    logic [1:0] cs;
    logic       hi_sel;
    logic [9:0] scan_full;

    assign cs        = {hi_cs, lo_cs};
    assign scan_full = {{(10 - obj_tab_aw){1'b0}}, scan_addr};

    always_ff @(posedge clk) begin
        for (int t = 0; t < 2; t++) begin
            if (cs[t] && !cpu_rnw) begin
                mem[t][cpu_addr] <= cpu_dout;
            end
            cpu_rd[t]  <= mem[t][cpu_addr];
            scan_rd[t] <= mem[t][scan_full];
        end
        // Select follows the read data by one cycle
        hi_sel <= hi_cs;
    end

    assign obj_dout = cpu_rd[hi_sel];
    assign lo_q     = scan_rd[0];
    assign hi_q     = scan_rd[1];

    a_one_cs: assert property (@(posedge clk) !(lo_cs && hi_cs));

endmodule

/* hw/sprite_scan.sv */
// Per-line sprite table scanner
module sprite_scan (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        hinit,
    input  logic                                        flip,
    input  logic [7:0]                                  vrender,
    output logic [obj_table_pkg::obj_tab_aw-1:0]        scan_addr,
    input  logic [7:0]                                  lo_q,
    input  logic [7:0]                                  hi_q,
    input  logic                                        dr_busy,
    output logic                                        cen2,
    output logic                                        dr_start,
    output logic [7:0]                                  dr_attr,
    output logic [7:0]                                  dr_code,
    output logic [7:0]                                  dr_xpos,
    output logic [$clog2(obj_table_pkg::obj_band)-1:0]  dr_row
);
    import obj_table_pkg::*;

    scan_state_t st;
    logic        hinit_x;
    logic        adj;
    logic        inzone;
    logic        last;
    logic [7:0]  vrf;
    logic [7:0]  spr_y;
    logic [7:0]  ydiff;

    // Raster count has already moved for the lower entries
    assign adj    = scan_addr[obj_tab_aw-1:1] < obj_half;
    assign vrf    = vrender ^ {8{flip}};
    assign spr_y  = ~lo_q + {7'd0, adj};
    assign inzone = (vrf >= spr_y) && ({1'b0, vrf} < {1'b0, spr_y} + 9'(obj_band));
    assign ydiff  = vrf - spr_y - 8'd1;
    assign last   = scan_addr[obj_tab_aw-1:1] == '0;

    // Half-rate enable, and hinit held until the scanner sees it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen2    <= 1'b0;
            hinit_x <= 1'b0;
        end else begin
            cen2 <= ~cen2;
            if (hinit) begin
                hinit_x <= 1'b1;
            end else if (cen2) begin
                hinit_x <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= idle;
            dr_start  <= 1'b0;
            scan_addr <= '0;
        end else if (cen2) begin
            dr_start <= 1'b0;
            case (st)
                idle: begin
                    if (hinit_x) begin
                        // Reverse scan from the top entry
                        scan_addr <= obj_tab_aw'(2 * (obj_entries - 1));
                        st        <= read_pos;
                    end
                end
                read_pos: begin
                    if (!dr_busy) begin
                        scan_addr[0] <= 1'b1;
                        st           <= read_code;
                    end
                end
                read_code: begin
                    scan_addr <= {scan_addr[obj_tab_aw-1:1] - 1'b1, 1'b0};
                    dr_start  <= inzone;
                    st        <= last ? idle : settle;
                end
                // Lets dr_busy rise before the next entry
                settle: st <= read_pos;
                default: st <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cen2) begin
            if (st == read_pos && !dr_busy) begin
                dr_xpos <= hi_q;
                dr_attr <= lo_q;
            end
            if (st == read_code) begin
                dr_code <= hi_q;
                dr_row  <= ydiff[$bits(dr_row)-1:0];
            end
        end
    end

    // Scanner must wait for the drawer before launching again
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        $rose(dr_start) |-> !dr_busy);

endmodule

/* hw/sprite_draw.sv */
// Sprite drawer with palette PROM
module sprite_draw (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        cen2,
    input  logic                                        dr_start,
    input  logic [7:0]                                  dr_attr,
    input  logic [7:0]                                  dr_code,
    input  logic [7:0]                                  dr_xpos,
    input  logic [$clog2(obj_table_pkg::obj_band)-1:0]  dr_row,
    output logic                                        dr_busy,
    output logic                                        rom_cs,
    output logic [obj_draw_pkg::gfx_aw-1:0]             rom_addr,
    input  logic [obj_draw_pkg::gfx_dw-1:0]             rom_data,
    input  logic                                        rom_ok,
    input  logic [7:0]                                  prog_addr,
    input  logic [obj_draw_pkg::pix_w-1:0]              prog_data,
    input  logic                                        prog_en,
    output logic                                        buf_we,
    output logic [7:0]                                  buf_addr,
    output logic [obj_draw_pkg::pix_w-1:0]              buf_data
);
    import obj_draw_pkg::*;

    draw_state_t                        st;
    logic [gfx_dw-1:0]                  pix_data;
    logic [$clog2(gfx_dw/pix_w)-1:0]    pix_cnt;
    logic [pix_w-1:0]                   palette [256];
    logic                               hflip;
    logic                               vflip;

    assign hflip = dr_attr[6];
    assign vflip = dr_attr[7];

    // Gather the four bit planes of each pixel into one nibble
    function automatic logic [gfx_dw-1:0] reorder(input logic [gfx_dw-1:0] w);
        logic [gfx_dw-1:0] r;
        int                base;
        int                j;
        for (int n = 0; n < gfx_dw / pix_w; n++) begin
            base       = (n / 4) * 16;
            j          = n % 4;
            r[4*n + 3] = w[base + 8 + j];
            r[4*n + 2] = w[base + 12 + j];
            r[4*n + 1] = w[base + j];
            r[4*n]     = w[base + 4 + j];
        end
        return r;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= idle;
            dr_busy  <= 1'b0;
            rom_cs   <= 1'b0;
            rom_addr <= '0;
            pix_cnt  <= '0;
        end else if (cen2) begin
            case (st)
                idle: begin
                    if (dr_start) begin
                        rom_addr <= {dr_code, dr_row ^ {$bits(dr_row){vflip}}, 1'b0};
                        rom_cs   <= 1'b1;
                        dr_busy  <= 1'b1;
                        st       <= fetch;
                    end
                end
                fetch: begin
                    if (rom_ok) begin
                        rom_cs  <= 1'b0;
                        pix_cnt <= '1;
                        st      <= shift;
                    end
                end
                shift: begin
                    pix_cnt <= pix_cnt - 1'b1;
                    if (pix_cnt == '0) begin
                        if (rom_addr[0]) begin
                            dr_busy <= 1'b0;
                            st      <= idle;
                        end else begin
                            // Second half of the sprite row
                            rom_addr[0] <= 1'b1;
                            rom_cs      <= 1'b1;
                            st          <= fetch;
                        end
                    end
                end
                default: st <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cen2) begin
            if (st == idle && dr_start) begin
                buf_addr <= dr_xpos + obj_hoffset + (hflip ? 8'd15 : 8'd0);
            end
            if (st == fetch && rom_ok) begin
                pix_data <= reorder(rom_data);
            end
            if (st == shift) begin
                pix_data <= pix_data >> pix_w;
                buf_addr <= hflip ? buf_addr - 8'd1 : buf_addr + 8'd1;
            end
        end
    end

    // Palette PROM, written by the loader
    always_ff @(posedge clk) begin
        if (prog_en) begin
            palette[prog_addr] <= prog_data;
        end
    end

    assign buf_data = palette[{dr_attr[3:0], pix_data[pix_w-1:0]}];
    assign buf_we   = cen2 && (st == shift);

    // Address must stay put while the ROM controller is busy with it
    a_rom_hold: assert property (@(posedge clk) disable iff (rst)
        (rom_cs && !rom_ok) |=> $stable(rom_addr));

endmodule

/* hw/line_buffer.sv */
// Double line buffer with read-and-erase
module line_buffer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            hinit,
    input  logic                            pxl_cen,
    input  logic                            LHBL,
    input  logic [7:0]                      hdump,
    input  logic                            buf_we,
    input  logic [7:0]                      buf_addr,
    input  logic [obj_draw_pkg::pix_w-1:0]  buf_data,
    output logic [obj_draw_pkg::pix_w-1:0]  pxl
);
    import obj_draw_pkg::*;

    logic [pix_w-1:0] mem [2][256];
    logic [pix_w-1:0] rd_data;
    logic             bank;
    logic             rd_en;

    // Drawer fills bank, display reads the other one
    assign rd_en   = pxl_cen && LHBL;
    assign rd_data = mem[~bank][hdump];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank <= 1'b0;
        end else if (hinit) begin
            bank <= ~bank;
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (b == bank) begin
                // Zero is transparent
                if (buf_we && buf_data != '0) begin
                    mem[b][buf_addr] <= buf_data;
                end
            end else if (rd_en) begin
                mem[b][hdump] <= '0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl <= '0;
        end else if (!LHBL) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= rd_data;
        end
    end

endmodule

/* hw/sprite_top.sv */
// Sprite engine top level
module sprite_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [9:0]                      cpu_addr,
    input  logic [7:0]                      cpu_dout,
    input  logic                            lo_cs,
    input  logic                            hi_cs,
    input  logic                            cpu_rnw,
    output logic [7:0]                      obj_dout,
    input  logic                            hinit,
    input  logic                            LHBL,
    input  logic                            pxl_cen,
    input  logic [7:0]                      vrender,
    input  logic [7:0]                      hdump,
    input  logic                            flip,
    input  logic [7:0]                      prog_addr,
    input  logic [obj_draw_pkg::pix_w-1:0]  prog_data,
    input  logic                            prog_en,
    output logic                            rom_cs,
    output logic [obj_draw_pkg::gfx_aw-1:0] rom_addr,
    input  logic [obj_draw_pkg::gfx_dw-1:0] rom_data,
    input  logic                            rom_ok,
    output logic [obj_draw_pkg::pix_w-1:0]  pxl
);
    import obj_table_pkg::*;
    import obj_draw_pkg::*;

    logic [obj_tab_aw-1:0]        scan_addr;
    logic [7:0]                   lo_q;
    logic [7:0]                   hi_q;
    logic                         cen2;
    logic                         dr_start;
    logic                         dr_busy;
    logic [7:0]                   dr_attr;
    logic [7:0]                   dr_code;
    logic [7:0]                   dr_xpos;
    logic [$clog2(obj_band)-1:0]  dr_row;
    logic                         buf_we;
    logic [7:0]                   buf_addr;
    logic [pix_w-1:0]             buf_data;

    sprite_ram i_sprite_ram (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .lo_cs     (lo_cs),
        .hi_cs     (hi_cs),
        .cpu_rnw   (cpu_rnw),
        .obj_dout  (obj_dout),
        .scan_addr (scan_addr),
        .lo_q      (lo_q),
        .hi_q      (hi_q)
    );

    sprite_scan i_sprite_scan (
        .clk       (clk),
        .rst       (rst),
        .hinit     (hinit),
        .flip      (flip),
        .vrender   (vrender),
        .scan_addr (scan_addr),
        .lo_q      (lo_q),
        .hi_q      (hi_q),
        .dr_busy   (dr_busy),
        .cen2      (cen2),
        .dr_start  (dr_start),
        .dr_attr   (dr_attr),
        .dr_code   (dr_code),
        .dr_xpos   (dr_xpos),
        .dr_row    (dr_row)
    );

    // Drawer steps on the scanner's enable
    sprite_draw i_sprite_draw (
        .clk       (clk),
        .rst       (rst),
        .cen2      (cen2),
        .dr_start  (dr_start),
        .dr_attr   (dr_attr),
        .dr_code   (dr_code),
        .dr_xpos   (dr_xpos),
        .dr_row    (dr_row),
        .dr_busy   (dr_busy),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_en   (prog_en),
        .buf_we    (buf_we),
        .buf_addr  (buf_addr),
        .buf_data  (buf_data)
    );

    line_buffer i_line_buffer (
        .clk       (clk),
        .rst       (rst),
        .hinit     (hinit),
        .pxl_cen   (pxl_cen),
        .LHBL      (LHBL),
        .hdump     (hdump),
        .buf_we    (buf_we),
        .buf_addr  (buf_addr),
        .buf_data  (buf_data),
        .pxl       (pxl)
    );

endmodule

/* sim/gfx_rom_model.sv */
// Graphics ROM model with variable latency
module gfx_rom_model #(
    parameter int seed_init = 1
) (
    input  logic                            clk,
    input  logic                            stall_en,
    input  logic                            rom_cs,
    input  logic [obj_draw_pkg::gfx_aw-1:0] rom_addr,
    output logic [obj_draw_pkg::gfx_dw-1:0] rom_data,
    output logic                            rom_ok
);
    import obj_draw_pkg::*;

    int   seed;
    int   wait_cnt;
    logic pending;

    // Contents are a fixed scramble of the address
    function automatic logic [gfx_dw-1:0] gfx_word(input logic [gfx_aw-1:0] a);
        return (32'(a) * 32'h9E3779B1) ^ {a[6:0], a, 12'hA5C};
    endfunction

    initial begin
        seed     = seed_init;
        rom_ok   = 1'b0;
        rom_data = '0;
        pending  = 1'b0;
        wait_cnt = 0;
    end

    // Outputs move on the falling edge like the rest of the stimulus
    always @(negedge clk) begin
        if (!rom_cs) begin
            rom_ok  <= 1'b0;
            pending <= 1'b0;
        end else if (!pending && !rom_ok) begin
            pending  <= 1'b1;
            wait_cnt <= stall_en ? ($random(seed) & 7) : 0;
        end else if (pending) begin
            if (wait_cnt == 0) begin
                rom_data <= gfx_word(rom_addr);
                rom_ok   <= 1'b1;
                pending  <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

/* sim/sprite_tb.sv */
// Sprite engine testbench
module sprite_tb;
    import obj_table_pkg::*;
    import obj_draw_pkg::*;

    localparam int clk_period    = 4;
    localparam int line_cycles   = 600;
    localparam int num_lines     = 9;
    localparam int watchdog_time = (num_lines + 3) * line_cycles * clk_period;
    localparam int rom_seed      = 80330;
    localparam int hidden_top    = 200;

    logic               clk;
    logic               rst;
    logic [9:0]         cpu_addr;
    logic [7:0]         cpu_dout;
    logic               lo_cs;
    logic               hi_cs;
    logic               cpu_rnw;
    logic [7:0]         obj_dout;
    logic               hinit;
    logic               LHBL;
    logic               pxl_cen;
    logic [7:0]         vrender;
    logic [7:0]         hdump;
    logic               flip;
    logic [7:0]         prog_addr;
    logic [pix_w-1:0]   prog_data;
    logic               prog_en;
    logic               rom_cs;
    logic [gfx_aw-1:0]  rom_addr;
    logic [gfx_dw-1:0]  rom_data;
    logic               rom_ok;
    logic [pix_w-1:0]   pxl;
    logic               stall_en;

    // Shadow copies of the sprite tables and the expected lines
    logic [7:0]         lo_tab [64];
    logic [7:0]         hi_tab [64];
    logic [pix_w-1:0]   exp_line [256];
    logic [pix_w-1:0]   next_exp [256];
    logic [pix_w-1:0]   exp_pxl;
    logic               check_en;
    longint             cycle = 0;
    longint             line_start;
    int                 errors = 0;
    int                 last_errors = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;
    int                 line_idx = 0;

    sprite_top i_sprite_top (.*);

    gfx_rom_model #(.seed_init(rom_seed)) rom_model (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Pixel shown one clk after each read strobe
    a_pixel: assert property (@(posedge clk) disable iff (rst || !check_en)
        (pxl_cen && LHBL) |=> (pxl == exp_pxl))
    else begin
        errors++;
        $display("ERR t=%0t pxl got %h exp %h", $time, pxl, exp_pxl);
    end

    a_blank: assert property (@(posedge clk) disable iff (rst)
        !LHBL |=> (pxl == '0))
    else begin
        errors++;
        $display("ERR t=%0t pxl got %h exp 0", $time, pxl);
    end

    initial begin
        #(watchdog_time);
        $display("Timeout: the run did not end within %0d lines", num_lines + 3);
        $display("=== FAIL ===");
        $finish;
    end

    // Must match the ROM model contents
    function automatic logic [gfx_dw-1:0] rom_word(input logic [gfx_aw-1:0] a);
        return (32'(a) * 32'h9E3779B1) ^ {a[6:0], a, 12'hA5C};
    endfunction

    // Pixel n takes bit j of four nibble lanes in its half word
    function automatic logic [3:0] plane_pixel(input logic [31:0] w, input int n);
        logic [15:0] h;
        int          j;
        h = w[16 * (n / 4) +: 16];
        j = n % 4;
        return {h[8 + j], h[12 + j], h[j], h[4 + j]};
    endfunction

    // Stored Y for a wanted top line, lower entries are seen one line late
    function automatic logic [7:0] stored_y(input int idx, input int top);
        return 8'(255 - top + (idx < obj_half ? 1 : 0));
    endfunction

    task automatic cpu_write(input logic hi, input logic [9:0] a, input logic [7:0] d);
        @(negedge clk);
        cpu_addr = a;
        cpu_dout = d;
        lo_cs    = !hi;
        hi_cs    = hi;
        cpu_rnw  = 1'b0;
        @(negedge clk);
        lo_cs   = 1'b0;
        hi_cs   = 1'b0;
        cpu_rnw = 1'b1;
        if (a < 64) begin
            if (hi) begin
                hi_tab[a] = d;
            end else begin
                lo_tab[a] = d;
            end
        end
    endtask

    task automatic cpu_read_check(input logic hi, input logic [9:0] a, input logic [7:0] exp);
        @(negedge clk);
        cpu_addr = a;
        lo_cs    = !hi;
        hi_cs    = hi;
        cpu_rnw  = 1'b1;
        @(negedge clk);
        assert (obj_dout == exp) else begin
            errors++;
            $display("ERR t=%0t obj_dout got %h exp %h", $time, obj_dout, exp);
        end
        lo_cs = 1'b0;
        hi_cs = 1'b0;
    endtask

    task automatic set_entry(input int idx, input logic [7:0] attr, input int top,
                             input logic [7:0] x, input logic [7:0] code);
        cpu_write(1'b0, 10'(2 * idx), attr);
        cpu_write(1'b0, 10'(2 * idx + 1), stored_y(idx, top));
        cpu_write(1'b1, 10'(2 * idx), x);
        cpu_write(1'b1, 10'(2 * idx + 1), code);
    endtask

    task automatic hide_entry(input int idx);
        cpu_write(1'b0, 10'(2 * idx + 1), stored_y(idx, hidden_top));
    endtask

    task automatic load_palette();
        for (int k = 0; k < 256; k++) begin
            @(negedge clk);
            prog_en   = 1'b1;
            prog_addr = 8'(k);
            prog_data = 4'((k % 15) + 1);
        end
        @(negedge clk);
        prog_en = 1'b0;
    endtask

    // Expected line buffer contents after one scan, later entries drawn on top
    task automatic model_line(input logic [7:0] vr, input logic fl);
        int         v;
        int         ytop;
        int         row;
        int         addr;
        logic [7:0] attr;
        logic [3:0] rr;
        logic [3:0] nib;
        for (int a = 0; a < 256; a++) begin
            next_exp[a] = '0;
        end
        v = fl ? 255 - int'(vr) : int'(vr);
        for (int i = obj_entries - 1; i >= 0; i--) begin
            attr = lo_tab[2 * i];
            ytop = (255 - int'(lo_tab[2 * i + 1]) + (i < obj_half ? 1 : 0)) % 256;
            if (v >= ytop && v < ytop + obj_band) begin
                row = (v - ytop - 1) & 15;
                rr  = attr[7] ? 4'(15 - row) : 4'(row);
                for (int k = 0; k < 16; k++) begin
                    nib  = plane_pixel(rom_word({hi_tab[2 * i + 1], rr, k >= 8}), k % 8);
                    addr = int'(hi_tab[2 * i]) + int'(obj_hoffset) + (attr[6] ? 15 - k : k);
                    next_exp[addr % 256] = 4'(((int'(attr[3:0]) * 16 + nib) % 15) + 1);
                end
            end
        end
    endtask

    // One video line, drawing this line and showing the previous one
    task automatic run_line(input logic [7:0] vr, input logic fl);
        @(negedge clk);
        line_start = cycle;
        vrender    = vr;
        flip       = fl;
        hinit      = 1'b1;
        check_en   = (line_idx >= 2);
        exp_line   = next_exp;
        model_line(vr, fl);
        @(negedge clk);
        hinit = 1'b0;
        for (int h = 0; h < 256; h++) begin
            LHBL    = 1'b1;
            pxl_cen = 1'b1;
            hdump   = 8'(h);
            exp_pxl = exp_line[h];
            @(negedge clk);
            pxl_cen = 1'b0;
            @(negedge clk);
        end
        LHBL = 1'b0;
        line_idx++;
    endtask

    task automatic end_line();
        while (cycle - line_start < line_cycles) begin
            @(negedge clk);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == last_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - last_errors);
        end
        last_errors = errors;
    endtask

    task automatic zone_config();
        set_entry(20, 8'h03, 52, 8'd40, 8'h21);
        set_entry(5, 8'h0A, 55, 8'd120, 8'h7C);
    endtask

    initial begin
        rst       = 1'b1;
        cpu_addr  = '0;
        cpu_dout  = '0;
        lo_cs     = 1'b0;
        hi_cs     = 1'b0;
        cpu_rnw   = 1'b1;
        hinit     = 1'b0;
        LHBL      = 1'b0;
        pxl_cen   = 1'b0;
        vrender   = '0;
        hdump     = '0;
        flip      = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        prog_en   = 1'b0;
        stall_en  = 1'b0;
        check_en  = 1'b0;
        exp_pxl   = '0;
        for (int a = 0; a < 256; a++) begin
            next_exp[a] = '0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        assert (rom_cs == 1'b0) else begin
            errors++;
            $display("ERR t=%0t rom_cs got %b exp 0", $time, rom_cs);
        end
        assert (pxl == '0) else begin
            errors++;
            $display("ERR t=%0t pxl got %h exp 0", $time, pxl);
        end
        cpu_write(1'b0, 10'h155, 8'hA5);
        cpu_write(1'b1, 10'h155, 8'h5A);
        cpu_write(1'b0, 10'h3FF, 8'h3C);
        cpu_write(1'b1, 10'h000, 8'hC3);
        cpu_read_check(1'b0, 10'h155, 8'hA5);
        cpu_read_check(1'b1, 10'h155, 8'h5A);
        cpu_read_check(1'b0, 10'h3FF, 8'h3C);
        cpu_read_check(1'b1, 10'h000, 8'hC3);
        report_test("reset_and_readback");

        load_palette();
        for (int i = 0; i < obj_entries; i++) begin
            set_entry(i, 8'h00, hidden_top, 8'h00, 8'h00);
        end

        // Both banks start unknown, two lines clear them
        run_line(8'd60, 1'b0);
        end_line();
        run_line(8'd60, 1'b0);
        zone_config();
        end_line();
        run_line(8'd60, 1'b0);
        hide_entry(20);
        hide_entry(5);
        set_entry(22, 8'h45, 80, 8'd10, 8'h33);
        set_entry(3, 8'h8C, 88, 8'd200, 8'h90);
        end_line();
        run_line(8'd90, 1'b0);
        report_test("zone_draw");

        // Entry 8 sits on the unflipped line only
        hide_entry(22);
        hide_entry(3);
        set_entry(21, 8'hC7, 95, 8'd240, 8'hE1);
        set_entry(8, 8'h02, 150, 8'd60, 8'h44);
        end_line();
        run_line(8'd155, 1'b1);
        hide_entry(21);
        hide_entry(8);
        end_line();
        run_line(8'd60, 1'b0);
        report_test("flip_draw");

        end_line();
        run_line(8'd60, 1'b0);
        stall_en = 1'b1;
        zone_config();
        end_line();
        run_line(8'd60, 1'b0);
        report_test("out_of_zone_erase");

        hide_entry(20);
        hide_entry(5);
        end_line();
        run_line(8'd60, 1'b0);
        report_test("rom_stall");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* sim.f */
hw/obj_table_pkg.sv
hw/obj_draw_pkg.sv
hw/sprite_ram.sv
hw/sprite_scan.sv
hw/sprite_draw.sv
hw/line_buffer.sv
hw/sprite_top.sv
sim/gfx_rom_model.sv
sim/sprite_tb.sv
